// ==== src/sd_cfg_pkg.sv ====
package sd_cfg_pkg;

    // Register address on the configuration port
    typedef logic [1:0] cfg_addr_t;

    // Address 0 holds enable and the modulator clock divider
    localparam cfg_addr_t ADDR_CONTROL = 2'd0;
    // Address 1 holds the decimation ratio as a power of two
    localparam cfg_addr_t ADDR_DECIMATION = 2'd1;

    typedef logic [7:0] clk_div_t;
    typedef logic [4:0] ratio_log2_t;

    // Control view of a write word
    typedef struct packed {
        logic [15:0] reserved_hi;
        clk_div_t    clk_div;
        logic [6:0]  reserved_lo;
        logic        enable;
    } ctrl_view_t;

    // Decimation view of the same word
    typedef struct packed {
        logic [26:0] reserved;
        ratio_log2_t ratio_log2;
    } dec_view_t;

    // The address picks which view applies
    typedef union packed {
        ctrl_view_t ctrl;
        dec_view_t  dec;
    } cfg_word_u;

    localparam clk_div_t    CLK_DIV_RESET    = 8'd1;
    // R of 64 out of reset
    localparam ratio_log2_t RATIO_LOG2_RESET = 5'd6;
    // Smallest accepted ratio is R of 4
    localparam ratio_log2_t RATIO_LOG2_MIN   = 5'd2;

endpackage

// ==== src/sd_data_pkg.sv ====
package sd_data_pkg;

    // Order of the CIC filter and also the number of frames dropped at start
    localparam int CIC_ORDER = 3;

    // Width of every integrator, comb and output word
    localparam int RESULT_WIDTH = 32;

    // Filter arithmetic wraps in two's complement at this width
    typedef logic signed [RESULT_WIDTH-1:0] result_t;

    // A modulator bit mapped to a signed value of +1 or -1
    typedef logic signed [1:0] sample_t;

    localparam sample_t SAMPLE_HIGH = 2'sb01;
    localparam sample_t SAMPLE_LOW  = 2'sb11;

    // Counts warm-up frames up to CIC_ORDER
    typedef logic [$clog2(CIC_ORDER + 1)-1:0] frame_count_t;

endpackage

// ==== src/sd_config_regs.sv ====
`timescale 1ns/10ps

module sd_config_regs #(
    parameter int MAX_RATIO_LOG2 = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cfg_write,
    input  sd_cfg_pkg::cfg_addr_t   cfg_addr,
    input  sd_cfg_pkg::cfg_word_u   cfg_data,
    output logic                    enable,
    output sd_cfg_pkg::clk_div_t    clk_div,
    output sd_cfg_pkg::ratio_log2_t ratio_log2,
    output logic                    cfg_changed
);

    logic ratio_ok;

    // A ratio outside the supported range leaves the old one in place
    assign ratio_ok = (cfg_data.dec.ratio_log2 >= sd_cfg_pkg::RATIO_LOG2_MIN) &&
                      (cfg_data.dec.ratio_log2 <= sd_cfg_pkg::ratio_log2_t'(MAX_RATIO_LOG2));

    always_ff @(posedge clk) begin
        if (reset) begin
            enable      <= 1'b0;
            clk_div     <= sd_cfg_pkg::CLK_DIV_RESET;
            ratio_log2  <= sd_cfg_pkg::RATIO_LOG2_RESET;
            cfg_changed <= 1'b0;
        end else begin
            cfg_changed <= 1'b0;
            if (cfg_write) begin
                case (cfg_addr)
                    sd_cfg_pkg::ADDR_CONTROL: begin
                        enable      <= cfg_data.ctrl.enable;
                        clk_div     <= cfg_data.ctrl.clk_div;
                        // Only a running demodulator needs a restart
                        cfg_changed <= enable;
                    end
                    sd_cfg_pkg::ADDR_DECIMATION: begin
                        if (ratio_ok) begin
                            ratio_log2  <= cfg_data.dec.ratio_log2;
                            cfg_changed <= enable;
                        end
                    end
                    // Other addresses are not mapped
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/sd_control_fsm.sv ====
`timescale 1ns/10ps

module sd_control_fsm (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic cfg_changed,
    input  logic warmup_done,
    output logic timer_run,
    output logic filter_clear,
    output logic out_enable
);

    typedef enum logic [1:0] {
        IDLE,
        FLUSH,
        WARMUP,
        RUN
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // Stay stopped until software sets enable
            IDLE: begin
                if (enable) begin
                    state_next = FLUSH;
                end
            end
            // Single cycle with the timer stopped and the filter cleared
            FLUSH: begin
                state_next = enable ? WARMUP : IDLE;
            end
            // Filter runs but its first frames are not settled yet
            WARMUP: begin
                if (!enable) begin
                    state_next = IDLE;
                end else if (cfg_changed) begin
                    state_next = FLUSH;
                end else if (warmup_done) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (!enable) begin
                    state_next = IDLE;
                end else if (cfg_changed) begin
                    state_next = FLUSH;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Outputs decode straight from the state register
    assign timer_run    = (state == WARMUP) || (state == RUN);
    assign filter_clear = (state == FLUSH);
    assign out_enable   = (state == RUN);

endmodule

// ==== src/sd_timer.sv ====
`timescale 1ns/10ps

module sd_timer #(
    parameter int MAX_RATIO_LOG2 = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    input  sd_cfg_pkg::clk_div_t    clk_div,
    input  sd_cfg_pkg::ratio_log2_t ratio_log2,
    output logic                    sd_clk,
    output logic                    sample_strobe,
    output logic                    frame_strobe,
    output logic                    warmup_done
);

    sd_cfg_pkg::clk_div_t      div_cnt;
    logic                      div_wrap;
    logic [MAX_RATIO_LOG2-1:0] sample_cnt;
    logic [MAX_RATIO_LOG2-1:0] sample_last;
    sd_data_pkg::frame_count_t frame_cnt;

    // Half period of sd_clk is clk_div+1 cycles
    assign div_wrap = run && (div_cnt == clk_div);

    // High in the cycle that ends with the rising edge of sd_clk
    // The filter samples data_in on that same edge
    assign sample_strobe = div_wrap && !sd_clk;

    // Index of the last sample in a frame is R-1
    assign sample_last  = MAX_RATIO_LOG2'((1 << ratio_log2) - 1);
    assign frame_strobe = sample_strobe && (sample_cnt == sample_last);

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            div_cnt     <= '0;
            sd_clk      <= 1'b0;
            sample_cnt  <= '0;
            frame_cnt   <= '0;
            warmup_done <= 1'b0;
        end else begin
            if (div_wrap) begin
                div_cnt <= '0;
                sd_clk  <= !sd_clk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sample_strobe) begin
                sample_cnt <= frame_strobe ? '0 : sample_cnt + 1'b1;
            end

            // Saturates once the warm-up frames have gone by
            if (frame_strobe &&
                (frame_cnt != sd_data_pkg::frame_count_t'(sd_data_pkg::CIC_ORDER))) begin
                frame_cnt <= frame_cnt + 1'b1;
            end

            // Held back one cycle so the last warm-up frame still meets a closed output
            warmup_done <= (frame_cnt == sd_data_pkg::frame_count_t'(sd_data_pkg::CIC_ORDER));
        end
    end

endmodule

// ==== src/cic_decimator.sv ====
`timescale 1ns/10ps

module cic_decimator #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear,
    input  logic                                  sample_strobe,
    input  logic                                  frame_strobe,
    input  logic [N_CHANNELS-1:0]                 data_in,
    output sd_data_pkg::result_t [N_CHANNELS-1:0] results,
    output logic                                  frame_valid
);

    localparam int ORDER = sd_data_pkg::CIC_ORDER;

    // Set on the edge that takes the last sample of a frame
    // The combs run one cycle later on the settled integrators
    logic comb_pending;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            comb_pending <= 1'b0;
            frame_valid  <= 1'b0;
        end else begin
            comb_pending <= sample_strobe && frame_strobe;
            frame_valid  <= comb_pending;
        end
    end

    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
        sd_data_pkg::sample_t sample;
        sd_data_pkg::result_t integ [ORDER];
        sd_data_pkg::result_t integ_next [ORDER];
        sd_data_pkg::result_t comb_dly [ORDER];
        sd_data_pkg::result_t comb_out [ORDER];

        // A one bit counts as +1 and a zero bit as -1
        assign sample = data_in[ch] ? sd_data_pkg::SAMPLE_HIGH : sd_data_pkg::SAMPLE_LOW;

        always_comb begin
            // Each integrator adds the freshly updated stage before it
            integ_next[0] = integ[0] + sd_data_pkg::result_t'(sample);
            for (int s = 1; s < ORDER; s++) begin
                integ_next[s] = integ[s] + integ_next[s-1];
            end
            // Each comb takes the difference against its input from the previous frame
            comb_out[0] = integ[ORDER-1] - comb_dly[0];
            for (int s = 1; s < ORDER; s++) begin
                comb_out[s] = comb_out[s-1] - comb_dly[s];
            end
        end

        always_ff @(posedge clk) begin
            if (reset || clear) begin
                for (int s = 0; s < ORDER; s++) begin
                    integ[s]    <= '0;
                    comb_dly[s] <= '0;
                end
            end else begin
                if (sample_strobe) begin
                    integ <= integ_next;
                end
                if (comb_pending) begin
                    comb_dly[0] <= integ[ORDER-1];
                    for (int s = 1; s < ORDER; s++) begin
                        comb_dly[s] <= comb_out[s-1];
                    end
                end
            end
        end

        // Result word only changes once per frame
        always_ff @(posedge clk) begin
            if (comb_pending) begin
                results[ch] <= comb_out[ORDER-1];
            end
        end
    end

endmodule

// ==== src/sd_output_mux.sv ====
`timescale 1ns/10ps

module sd_output_mux #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      enable,
    input  sd_data_pkg::result_t [N_CHANNELS-1:0]     results,
    input  logic                                      frame_valid,
    output logic                                      out_valid,
    output logic [$clog2(N_CHANNELS > 1 ? N_CHANNELS : 2)-1:0] out_dest,
    output sd_data_pkg::result_t                      out_data
);

    localparam int DEST_WIDTH = $clog2(N_CHANNELS > 1 ? N_CHANNELS : 2);

    // Copy of the frame being sent out
    sd_data_pkg::result_t [N_CHANNELS-1:0] frame_buf;
    logic [DEST_WIDTH-1:0]                 dest_next;
    logic                                  last_channel;

    assign dest_next    = out_dest + 1'b1;
    assign last_channel = (out_dest == DEST_WIDTH'(N_CHANNELS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_dest  <= '0;
        end else if (frame_valid && enable) begin
            // Channel 0 goes out in the cycle after frame_valid
            out_valid <= 1'b1;
            out_dest  <= '0;
        end else if (out_valid && !last_channel) begin
            out_dest <= dest_next;
        end else begin
            // A group once started always finishes
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid && enable) begin
            frame_buf <= results;
            out_data  <= results[0];
        end else if (out_valid && !last_channel) begin
            out_data <= frame_buf[dest_next];
        end
    end

endmodule

// ==== src/sd_processor.sv ====
`timescale 1ns/10ps

module sd_processor #(
    parameter int N_CHANNELS     = 4,
    parameter int MAX_RATIO_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_write,
    input  sd_cfg_pkg::cfg_addr_t cfg_addr,
    input  sd_cfg_pkg::cfg_word_u cfg_data,
    input  logic [N_CHANNELS-1:0] data_in,
    output logic                  sd_clk,
    output logic                  out_valid,
    output logic [$clog2(N_CHANNELS > 1 ? N_CHANNELS : 2)-1:0] out_dest,
    output sd_data_pkg::result_t  out_data
);

    // Configuration state
    logic                    enable;
    sd_cfg_pkg::clk_div_t    clk_div;
    sd_cfg_pkg::ratio_log2_t ratio_log2;
    logic                    cfg_changed;

    // Sequencing
    logic timer_run;
    logic filter_clear;
    logic out_enable;
    logic warmup_done;

    // Sample and frame timing
    logic sample_strobe;
    logic frame_strobe;

    // Filter output
    sd_data_pkg::result_t [N_CHANNELS-1:0] results;
    logic                                  frame_valid;

    sd_config_regs #(
        .MAX_RATIO_LOG2(MAX_RATIO_LOG2)
    ) u_config_regs (
        .clk(clk),
        .reset(reset),
        .cfg_write(cfg_write),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .enable(enable),
        .clk_div(clk_div),
        .ratio_log2(ratio_log2),
        .cfg_changed(cfg_changed)
    );

    sd_control_fsm u_control_fsm (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .cfg_changed(cfg_changed),
        .warmup_done(warmup_done),
        .timer_run(timer_run),
        .filter_clear(filter_clear),
        .out_enable(out_enable)
    );

    sd_timer #(
        .MAX_RATIO_LOG2(MAX_RATIO_LOG2)
    ) u_timer (
        .clk(clk),
        .reset(reset),
        .run(timer_run),
        .clk_div(clk_div),
        .ratio_log2(ratio_log2),
        .sd_clk(sd_clk),
        .sample_strobe(sample_strobe),
        .frame_strobe(frame_strobe),
        .warmup_done(warmup_done)
    );

    cic_decimator #(
        .N_CHANNELS(N_CHANNELS)
    ) u_cic_decimator (
        .clk(clk),
        .reset(reset),
        .clear(filter_clear),
        .sample_strobe(sample_strobe),
        .frame_strobe(frame_strobe),
        .data_in(data_in),
        .results(results),
        .frame_valid(frame_valid)
    );

    sd_output_mux #(
        .N_CHANNELS(N_CHANNELS)
    ) u_output_mux (
        .clk(clk),
        .reset(reset),
        .enable(out_enable),
        .results(results),
        .frame_valid(frame_valid),
        .out_valid(out_valid),
        .out_dest(out_dest),
        .out_data(out_data)
    );

endmodule

// ==== test/sd_processor_tb.sv ====
`timescale 1ns/10ps

module sd_processor_tb;

    localparam int N_CHANNELS     = 4;
    localparam int MAX_RATIO_LOG2 = 8;
    localparam int DEST_WIDTH     = $clog2(N_CHANNELS > 1 ? N_CHANNELS : 2);
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int IDLE_CYCLES    = 200;

    // Divider and ratio used in each phase of the run
    localparam int DIV_A    = 1;
    localparam int DIV_B    = 4;
    localparam int RLOG_AB  = 6;
    localparam int RLOG_C   = 4;
    localparam int GROUPS_A = 4;
    localparam int GROUPS_B = 3;
    localparam int GROUPS_C = 3;

    // Each phase pays for the dropped warm-up frames plus some slack for alignment
    localparam int FRAMES_A    = sd_data_pkg::CIC_ORDER + GROUPS_A + 2;
    localparam int FRAMES_B    = sd_data_pkg::CIC_ORDER + GROUPS_B + 2;
    localparam int FRAMES_C    = sd_data_pkg::CIC_ORDER + 2 * GROUPS_C + 2;
    localparam int FRAMES_D    = 2;
    localparam int STOP_CYCLES = FRAMES_D * (1 << RLOG_C) * 2 * (DIV_B + 1);
    localparam int RUN_CYCLES  = FRAMES_A * (1 << RLOG_AB) * 2 * (DIV_A + 1) +
                                 FRAMES_B * (1 << RLOG_AB) * 2 * (DIV_B + 1) +
                                 FRAMES_C * (1 << RLOG_C) * 2 * (DIV_B + 1) + STOP_CYCLES;
    localparam int WATCHDOG_NS = (RESET_CYCLES + IDLE_CYCLES + RUN_CYCLES + 500) * CLK_PERIOD;

    // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_SEED = 16'd30703;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic                  clk       = 1'b0;
    logic                  reset     = 1'b1;
    logic                  cfg_write = 1'b0;
    sd_cfg_pkg::cfg_addr_t cfg_addr  = '0;
    sd_cfg_pkg::cfg_word_u cfg_data  = '0;
    logic [N_CHANNELS-1:0] data_in   = '0;
    logic                  sd_clk;
    logic                  out_valid;
    logic [DEST_WIDTH-1:0] out_dest;
    sd_data_pkg::result_t  out_data;

    // Modulator bits in the order the DUT sampled them since the last start
    logic [N_CHANNELS-1:0] samples [$];
    logic [15:0]           lfsr = LFSR_SEED;
    logic                  sd_clk_prev = 1'b0;
    int                    discard_left = 0;
    int                    restart_count = 0;
    int                    restart_seen = 0;
    int                    model_ratio_log2 = RLOG_AB;
    logic                  outputs_allowed = 1'b0;
    int                    groups_done = 0;
    int                    epoch_seen = 0;
    int                    expected_dest = 0;
    int                    expected_frame = 0;

    sd_processor #(
        .N_CHANNELS(N_CHANNELS),
        .MAX_RATIO_LOG2(MAX_RATIO_LOG2)
    ) u_sd_processor (
        .clk(clk),
        .reset(reset),
        .cfg_write(cfg_write),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .data_in(data_in),
        .sd_clk(sd_clk),
        .out_valid(out_valid),
        .out_dest(out_dest),
        .out_data(out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ LFSR_TAPS;
        end
        return stepped;
    endfunction

    // Third-order CIC over the recorded bits with a fresh filter at the first sample
    function automatic sd_data_pkg::result_t cic_reference(input int ch, input int frame,
                                                          input int ratio_log2);
        sd_data_pkg::result_t i0, i1, i2;
        sd_data_pkg::result_t d0, d1, d2;
        sd_data_pkg::result_t c0, c1, c2;
        int r;
        r  = 1 << ratio_log2;
        i0 = '0;
        i1 = '0;
        i2 = '0;
        d0 = '0;
        d1 = '0;
        d2 = '0;
        c2 = '0;
        for (int f = 0; f < frame; f++) begin
            for (int n = 0; n < r; n++) begin
                // A one bit counts as +1 and a zero bit as -1
                i0 = samples[f * r + n][ch] ? i0 + 1 : i0 - 1;
                i1 = i1 + i0;
                i2 = i2 + i1;
            end
            c0 = i2 - d0;
            d0 = i2;
            c1 = c0 - d1;
            d1 = c0;
            c2 = c1 - d2;
            d2 = c1;
        end
        return c2;
    endfunction

    function automatic sd_cfg_pkg::cfg_word_u control_word(input logic enable, input int div);
        sd_cfg_pkg::cfg_word_u word;
        word              = '0;
        word.ctrl.enable  = enable;
        word.ctrl.clk_div = sd_cfg_pkg::clk_div_t'(div);
        return word;
    endfunction

    function automatic sd_cfg_pkg::cfg_word_u decimation_word(input int ratio_log2);
        sd_cfg_pkg::cfg_word_u word;
        word                = '0;
        word.dec.ratio_log2 = sd_cfg_pkg::ratio_log2_t'(ratio_log2);
        return word;
    endfunction

    task automatic check_result(input sd_data_pkg::result_t got,
                                input sd_data_pkg::result_t expected);
        if (got !== expected) begin
            $display("FAIL out_data got %h expected %h (channel %0d, frame %0d)",
                     got, expected, expected_dest, expected_frame);
            fail_run();
        end
    endtask

    task automatic check_dest(input logic [DEST_WIDTH-1:0] got,
                              input logic [DEST_WIDTH-1:0] expected);
        if (got !== expected) begin
            $display("FAIL out_dest got %h expected %h", got, expected);
            fail_run();
        end
    endtask

    task automatic check_period(input int got, input int expected);
        if (got != expected) begin
            $display("FAIL sd_clk period got %h expected %h", got, expected);
            fail_run();
        end
    endtask

    // One strobed write plus a note to the bit recorder when the filter will restart
    task automatic write_config(input sd_cfg_pkg::cfg_addr_t addr,
                                input sd_cfg_pkg::cfg_word_u word, input logic restarts);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = word;
        if (restarts) begin
            restart_count = restart_count + 1;
        end
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    // Time between two rising edges of sd_clk in clk cycles
    task automatic measure_period(output int cycles);
        realtime first_rise;
        @(posedge sd_clk);
        first_rise = $realtime;
        @(posedge sd_clk);
        cycles = int'(($realtime - first_rise) / CLK_PERIOD);
    endtask

    task automatic wait_groups(input int count);
        int target;
        target = groups_done + count;
        while (groups_done < target) begin
            @(negedge clk);
        end
    endtask

    // Records the bit sampled at each rise of sd_clk and drives the next one
    always @(negedge clk) begin
        logic [N_CHANNELS-1:0] fresh;
        // Samples up to the flush belong to a filter that is about to be cleared
        // Three negedges cover the flush whichever side of this edge the write landed on
        if (restart_seen != restart_count) begin
            restart_seen = restart_count;
            samples.delete();
            discard_left = 3;
        end
        if (sd_clk === 1'b1 && sd_clk_prev === 1'b0) begin
            if (discard_left == 0) begin
                samples.push_back(data_in);
            end
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                fresh[ch] = lfsr[0];
                lfsr      = lfsr_next(lfsr);
            end
            data_in = fresh;
        end
        if (discard_left > 0) begin
            discard_left = discard_left - 1;
        end
        sd_clk_prev = sd_clk;
    end

    // Checks every output cycle against the model
    always @(negedge clk) begin
        int frame;
        if (out_valid === 1'b1) begin
            if (!outputs_allowed) begin
                $display("Output appeared while the demodulator was disabled");
                fail_run();
            end
            // The first group after a start must come from the frame after warm-up
            if (epoch_seen != restart_seen) begin
                epoch_seen     = restart_seen;
                expected_frame = sd_data_pkg::CIC_ORDER + 1;
            end
            if (expected_dest == 0) begin
                frame = samples.size() >> model_ratio_log2;
                if (frame != expected_frame) begin
                    $display("Output group belongs to frame %0d but frame %0d was due",
                             frame, expected_frame);
                    fail_run();
                end
            end
            check_dest(out_dest, DEST_WIDTH'(expected_dest));
            check_result(out_data, cic_reference(expected_dest, expected_frame,
                                                 model_ratio_log2));
            if (expected_dest == N_CHANNELS - 1) begin
                expected_dest  = 0;
                expected_frame = expected_frame + 1;
                groups_done    = groups_done + 1;
            end else begin
                expected_dest = expected_dest + 1;
            end
        end else if (expected_dest != 0) begin
            $display("Output group ended after %0d of %0d channels", expected_dest, N_CHANNELS);
            fail_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run did not finish within %0d ns", WATCHDOG_NS);
        fail_run();
    end

    initial begin
        int period;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Disabled out of reset so the modulator clock stays parked
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (sd_clk !== 1'b0) begin
                $display("sd_clk moved while the demodulator was disabled");
                fail_run();
            end
        end

        // Start with R of 64 and the fastest divider under test
        outputs_allowed = 1'b1;
        write_config(sd_cfg_pkg::ADDR_CONTROL, control_word(1'b1, DIV_A), 1'b1);
        measure_period(period);
        check_period(period, 2 * (DIV_A + 1));
        wait_groups(GROUPS_A);

        // A new divider while running flushes the filter
        write_config(sd_cfg_pkg::ADDR_CONTROL, control_word(1'b1, DIV_B), 1'b1);
        measure_period(period);
        check_period(period, 2 * (DIV_B + 1));
        wait_groups(GROUPS_B);

        // R of 16 restarts the filter with a new warm-up
        model_ratio_log2 = RLOG_C;
        write_config(sd_cfg_pkg::ADDR_DECIMATION, decimation_word(RLOG_C), 1'b1);
        wait_groups(GROUPS_C);

        // R of 2 is below the minimum so the stream carries on untouched
        write_config(sd_cfg_pkg::ADDR_DECIMATION, decimation_word(1), 1'b0);
        wait_groups(GROUPS_C);

        // Disable and expect silence
        outputs_allowed = 1'b0;
        write_config(sd_cfg_pkg::ADDR_CONTROL, control_word(1'b0, DIV_B), 1'b0);
        repeat (4) @(negedge clk);
        repeat (STOP_CYCLES) begin
            @(negedge clk);
            if (sd_clk !== 1'b0) begin
                $display("sd_clk kept running after enable was cleared");
                fail_run();
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
src/sd_cfg_pkg.sv
src/sd_data_pkg.sv
src/sd_config_regs.sv
src/sd_control_fsm.sv
src/sd_timer.sv
src/cic_decimator.sv
src/sd_output_mux.sv
src/sd_processor.sv
test/sd_processor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
# The run counts as passed only if the pass line shows up in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/10ps \
        --top-module sd_processor_tb -f src.f -o sd_processor_sim \
    && ./obj_dir/sd_processor_sim | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
